// ==== filelist.f ====
+incdir+hw
hw/xv_bus_pkg.sv
hw/xv_video_pkg.sv
hw/vram_arb.sv
hw/video_gen.sv
hw/blit_fill.sv
hw/reg_interface.sv
hw/xosera_main.sv
sim/tb_xosera.sv

// ==== hw/blit_fill.sv ====
/*
 * fill blitter
 * writes one value to count consecutive VRAM words from a start
 * address, done strobe when the last write is acked
 */
`default_nettype none

module blit_fill (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   start_i,
    input  wire xv_video_pkg::word_t    count_i,
    input  wire xv_video_pkg::word_t    value_i,
    input  wire xv_video_pkg::addr_t    addr_i,
    input  wire logic                   vram_ack_i,
    output logic                        vram_sel_o,
    output logic                        vram_wr_o,
    output xv_video_pkg::addr_t         vram_addr_o,
    output xv_video_pkg::word_t         vram_data_o,
    output logic                        busy_o,
    output logic                        done_o
);

xv_video_pkg::word_t    remaining;      // words still to write

assign vram_sel_o = busy_o;
assign vram_wr_o  = busy_o;             // writes only

always_ff @(posedge clk) begin
    if (start_i) begin
        vram_addr_o <= addr_i;
        vram_data_o <= value_i;
    end else if (vram_ack_i) begin
        vram_addr_o <= vram_addr_o + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        remaining <= '0;
        busy_o    <= 1'b0;
        done_o    <= 1'b0;
    end else begin
        done_o <= 1'b0;
        if (start_i) begin
            remaining <= count_i;
            busy_o    <= (count_i != '0);
            done_o    <= (count_i == '0);   // empty fill
        end else if (busy_o && vram_ack_i) begin
            remaining <= remaining - 1'b1;
            if (remaining == xv_video_pkg::word_t'(1)) begin
                busy_o <= 1'b0;
                done_o <= 1'b1;
            end
        end
    end
end

// CPU must not restart a fill in progress
assert property (@(posedge clk) disable iff (reset_i) start_i |-> !busy_o);

endmodule

`default_nettype wire

// ==== hw/reg_interface.sv ====
/*
 * CPU register interface
 * 8-bit bus with byte select into 16-bit registers, CPU reads and
 * writes of VRAM through the arbiter, fill blit control and the
 * interrupt status/mask logic
 */
`default_nettype none
`include "xosera_consts.svh"

module reg_interface (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_cs_n_i,     // select, active low
    input  wire logic                   bus_rd_nwr_i,   // 1 read, 0 write
    input  wire xv_bus_pkg::reg_num_t   bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,  // 0 = even (high) byte
    input  wire xv_bus_pkg::bus_byte_t  bus_data_i,
    output xv_bus_pkg::bus_byte_t       bus_data_o,
    output logic                        bus_intr_o,
    output logic                        regs_sel_o,     // VRAM request
    output logic                        regs_wr_o,
    output xv_video_pkg::addr_t         regs_addr_o,
    output xv_video_pkg::word_t         regs_data_o,
    input  wire logic                   regs_ack_i,
    input  wire xv_video_pkg::word_t    vram_data_i,
    output logic                        blit_start_o,
    output xv_video_pkg::word_t         blit_count_o,
    output xv_video_pkg::word_t         blit_value_o,
    output xv_video_pkg::addr_t         blit_addr_o,
    input  wire logic                   blit_busy_i,
    input  wire logic                   blit_done_i,
    input  wire logic                   h_blank_i,
    input  wire logic                   v_blank_i,
    input  wire logic                   video_intr_i
);

logic                   cs_n_q;         // select last cycle
logic                   bus_access;     // first cycle of select
logic                   commit;         // odd byte write
logic                   xm_data_sel;    // XM_DATA addressed
logic                   xm_start;       // accepted VRAM request
xv_bus_pkg::bus_byte_t  hi_latch;       // even byte waiting for commit
xv_video_pkg::word_t    wr_word;
xv_video_pkg::word_t    rd_word;
xv_video_pkg::addr_t    xm_addr;
xv_video_pkg::word_t    rd_buf;         // word at XM_ADDR
logic                   reg_busy;
logic                   ack_q;          // vram data valid now
logic                   latch_q;        // rd_buf loaded last cycle
xv_bus_pkg::intr_t      intr_mask;
xv_bus_pkg::intr_t      intr_status;    // pending
xv_bus_pkg::intr_t      intr_clear;     // one-cycle clear from CPU
xv_bus_pkg::intr_t      intr_trigger;

assign bus_access   = cs_n_q && !bus_cs_n_i;
assign commit       = bus_access && !bus_rd_nwr_i && bus_bytesel_i;
assign wr_word      = {hi_latch, bus_data_i};
assign xm_data_sel  = (bus_reg_num_i == xv_bus_pkg::reg_num_t'(`XV_REG_XM_DATA));
assign xm_start     = commit && !reg_busy &&
                      (xm_data_sel || bus_reg_num_i == xv_bus_pkg::reg_num_t'(`XV_REG_XM_ADDR));
assign blit_addr_o  = xm_addr;          // fill starts at current address

always_comb begin
    intr_trigger                 = '0;
    intr_trigger[`XV_INTR_VIDEO] = video_intr_i;
    intr_trigger[`XV_INTR_BLIT]  = blit_done_i;
end

// register read mux
always_comb begin
    case (bus_reg_num_i)
        `XV_REG_XM_ADDR:    rd_word = xv_video_pkg::word_t'(xm_addr);
        `XV_REG_XM_DATA:    rd_word = rd_buf;
        `XV_REG_BLIT_COUNT: rd_word = blit_count_o;
        `XV_REG_BLIT_VALUE: rd_word = blit_value_o;
        `XV_REG_INT_CTRL:   rd_word = {6'b0, intr_mask, 6'b0, intr_status};
        `XV_REG_STATUS:     rd_word = {12'b0, v_blank_i, h_blank_i, blit_busy_i, reg_busy};
        default:            rd_word = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_n_q       <= 1'b1;
        bus_data_o   <= '0;
        regs_sel_o   <= 1'b0;
        regs_wr_o    <= 1'b0;
        reg_busy     <= 1'b0;
        ack_q        <= 1'b0;
        latch_q      <= 1'b0;
        xm_addr      <= '0;
        blit_start_o <= 1'b0;
        intr_mask    <= '0;
        intr_clear   <= '0;
    end else begin
        cs_n_q       <= bus_cs_n_i;
        blit_start_o <= 1'b0;           // strobes
        intr_clear   <= '0;
        ack_q        <= regs_sel_o && regs_ack_i;
        latch_q      <= ack_q;
        if (regs_sel_o && regs_ack_i) begin
            regs_sel_o <= 1'b0;
        end
        if (latch_q) begin
            reg_busy <= 1'b0;           // one cycle after rd_buf load
        end
        if (bus_access && bus_rd_nwr_i) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
        end
        if (xm_start) begin
            regs_sel_o <= 1'b1;
            regs_wr_o  <= xm_data_sel;
            reg_busy   <= 1'b1;
            xm_addr    <= xm_data_sel ? xm_addr + 1'b1 : xv_video_pkg::addr_t'(wr_word);
        end
        if (commit && bus_reg_num_i == xv_bus_pkg::reg_num_t'(`XV_REG_BLIT_COUNT)) begin
            blit_start_o <= 1'b1;
        end
        if (commit && bus_reg_num_i == xv_bus_pkg::reg_num_t'(`XV_REG_INT_CTRL)) begin
            intr_mask  <= wr_word[8 +: $bits(xv_bus_pkg::intr_t)];
            intr_clear <= wr_word[0 +: $bits(xv_bus_pkg::intr_t)];   // write 1 to clear
        end
    end
end

// data registers
always_ff @(posedge clk) begin
    if (bus_access && !bus_rd_nwr_i && !bus_bytesel_i) begin
        hi_latch <= bus_data_i;
    end
    if (ack_q && !regs_wr_o) begin
        rd_buf <= vram_data_i;          // read data one cycle after ack
    end
    if (xm_start) begin
        regs_addr_o <= xm_data_sel ? xm_addr : xv_video_pkg::addr_t'(wr_word);
        regs_data_o <= wr_word;
    end
    if (commit && bus_reg_num_i == xv_bus_pkg::reg_num_t'(`XV_REG_BLIT_COUNT)) begin
        blit_count_o <= wr_word;
    end
    if (commit && bus_reg_num_i == xv_bus_pkg::reg_num_t'(`XV_REG_BLIT_VALUE)) begin
        blit_value_o <= wr_word;
    end
end

// interrupt status and bus strobe
always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_intr_o  <= 1'b0;
        intr_status <= '0;
    end else begin
        bus_intr_o  <= |(intr_trigger & intr_mask & ~intr_status);  // new and enabled only
        intr_status <= (intr_status | intr_trigger) & ~intr_clear;
    end
end

// request held until the arbiter grants it
assert property (@(posedge clk) disable iff (reset_i)
    regs_sel_o && !regs_ack_i |=> regs_sel_o);

// no strobe with every source masked
assert property (@(posedge clk) disable iff (reset_i)
    intr_mask == '0 |=> !bus_intr_o);

endmodule

`default_nettype wire

// ==== hw/video_gen.sv ====
/*
 * video generator
 * raster counters, sync and display enable, 4 bpp pixel fetch from
 * VRAM one word ahead, grey ramp output of the pixel index
 */
`default_nettype none
`include "xosera_consts.svh"

module video_gen (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    output logic                        vram_sel_o,
    output xv_video_pkg::addr_t         vram_addr_o,
    input  wire logic                   vram_ack_i,
    input  wire xv_video_pkg::word_t    vram_data_i,
    output xv_video_pkg::rgb4_t         red_o,
    output xv_video_pkg::rgb4_t         green_o,
    output xv_video_pkg::rgb4_t         blue_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o,
    output logic                        h_blank_o,
    output logic                        v_blank_o,
    output logic                        video_intr_o
);

xv_video_pkg::hcount_t  h_count;
xv_video_pkg::vcount_t  v_count;
xv_video_pkg::hcount_t  h_ahead;        // column four pixels ahead
xv_video_pkg::vcount_t  v_ahead;        // line of that column
xv_video_pkg::word_t    fetch_word;     // next group of four pixels
xv_video_pkg::word_t    pix_word;       // shifting, msn is current pixel
logic                   fetch_valid;    // vram data is ours this cycle
logic                   visible;

assign visible      = (h_count < xv_video_pkg::hcount_t'(`XV_H_VISIBLE)) &&
                      (v_count < xv_video_pkg::vcount_t'(`XV_V_VISIBLE));
assign h_blank_o    = (h_count >= xv_video_pkg::hcount_t'(`XV_H_VISIBLE));
assign v_blank_o    = (v_count >= xv_video_pkg::vcount_t'(`XV_V_VISIBLE));
assign video_intr_o = (h_count == '0) && (v_count == xv_video_pkg::vcount_t'(`XV_V_VISIBLE));
assign vram_sel_o   = (h_count[1:0] == 2'b00);     // one cycle in four

// address of the word for the next group, wrapping into the next line
always_comb begin
    h_ahead = h_count + xv_video_pkg::hcount_t'(4);
    v_ahead = v_count;
    if (h_ahead >= xv_video_pkg::hcount_t'(`XV_H_TOTAL)) begin
        h_ahead = h_ahead - xv_video_pkg::hcount_t'(`XV_H_TOTAL);
        v_ahead = (v_count == xv_video_pkg::vcount_t'(`XV_V_TOTAL - 1)) ? '0 : v_count + 1'b1;
    end
end

assign vram_addr_o = xv_video_pkg::addr_t'({v_ahead, 2'b00}) + xv_video_pkg::addr_t'(h_ahead[4:2]);

// raster counters
always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count <= '0;
        v_count <= '0;
    end else if (h_count == xv_video_pkg::hcount_t'(`XV_H_TOTAL - 1)) begin
        h_count <= '0;
        v_count <= (v_count == xv_video_pkg::vcount_t'(`XV_V_TOTAL - 1)) ? '0 : v_count + 1'b1;
    end else begin
        h_count <= h_count + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (fetch_valid) begin
        fetch_word <= vram_data_i;      // lands at pixel 1 of the group
    end
end

// outputs one cycle behind the counters
always_ff @(posedge clk) begin
    if (reset_i) begin
        fetch_valid <= 1'b0;
        pix_word    <= '0;
        dv_de_o     <= 1'b0;
        hsync_o     <= 1'b0;
        vsync_o     <= 1'b0;
        red_o       <= '0;
        green_o     <= '0;
        blue_o      <= '0;
    end else begin
        fetch_valid <= vram_ack_i;
        if (h_count[1:0] == 2'b11) begin
            pix_word <= fetch_word;     // group boundary
        end else begin
            pix_word <= {pix_word[11:0], 4'h0};
        end
        dv_de_o <= visible;
        hsync_o <= (h_count >= xv_video_pkg::hcount_t'(`XV_H_SYNC_START)) &&
                   (h_count <  xv_video_pkg::hcount_t'(`XV_H_SYNC_END));
        vsync_o <= (v_count == xv_video_pkg::vcount_t'(`XV_V_SYNC_LINE));
        red_o   <= visible ? pix_word[15:12] : '0;     // grey ramp
        green_o <= visible ? pix_word[15:12] : '0;
        blue_o  <= visible ? pix_word[15:12] : '0;
    end
end

endmodule

`default_nettype wire

// ==== hw/vram_arb.sv ====
/*
 * video RAM and arbiter
 * 4096 x 16 memory shared by video, blit and CPU registers,
 * one client per cycle in fixed priority, read data one cycle after ack
 */
`default_nettype none
`include "xosera_consts.svh"

module vram_arb (
    input  wire logic                   clk,
    input  wire logic                   vgen_sel_i,     // read only
    input  wire xv_video_pkg::addr_t    vgen_addr_i,
    input  wire logic                   blit_sel_i,
    input  wire logic                   blit_wr_i,
    input  wire xv_video_pkg::addr_t    blit_addr_i,
    input  wire xv_video_pkg::word_t    blit_data_i,
    input  wire logic                   regs_sel_i,
    input  wire logic                   regs_wr_i,
    input  wire xv_video_pkg::addr_t    regs_addr_i,
    input  wire xv_video_pkg::word_t    regs_data_i,
    output logic                        vgen_ack_o,
    output logic                        blit_ack_o,
    output logic                        regs_ack_o,
    output xv_video_pkg::word_t         vram_data_o     // shared by all clients
);

xv_video_pkg::word_t    mem [0:(1 << `XV_ADDR_W) - 1];
xv_video_pkg::addr_t    mem_addr;
xv_video_pkg::word_t    mem_data;
logic                   mem_wr;

// video, then blit, then registers
always_comb begin
    vgen_ack_o = vgen_sel_i;
    blit_ack_o = blit_sel_i && !vgen_sel_i;
    regs_ack_o = regs_sel_i && !vgen_sel_i && !blit_sel_i;

    mem_addr = regs_addr_i;
    mem_data = regs_data_i;
    mem_wr   = regs_ack_o && regs_wr_i;
    if (vgen_sel_i) begin
        mem_addr = vgen_addr_i;
        mem_wr   = 1'b0;
    end else if (blit_sel_i) begin
        mem_addr = blit_addr_i;
        mem_data = blit_data_i;
        mem_wr   = blit_wr_i;
    end
end

always_ff @(posedge clk) begin
    if (mem_wr) begin
        mem[mem_addr] <= mem_data;
    end
    vram_data_o <= mem[mem_addr];   // old data on a write cycle
end

assert property (@(posedge clk) $onehot0({vgen_ack_o, blit_ack_o, regs_ack_o}));

endmodule

`default_nettype wire

// ==== hw/xosera_consts.svh ====
/*
 * video display constants
 * memory widths, CPU register numbers, interrupt bits and the
 * small test video timing
 */
`ifndef XOSERA_CONSTS_SVH
`define XOSERA_CONSTS_SVH

`define XV_ADDR_W           12      // VRAM word address bits
`define XV_WORD_W           16      // VRAM and register word bits

// video timing, pixels per line and lines per frame
`define XV_H_VISIBLE        16
`define XV_H_TOTAL          24
`define XV_V_VISIBLE        8
`define XV_V_TOTAL          12
`define XV_H_SYNC_START     18      // first hsync column
`define XV_H_SYNC_END       20      // first column after hsync
`define XV_V_SYNC_LINE      10      // only vsync line

// CPU register numbers
`define XV_REG_XM_ADDR      0
`define XV_REG_XM_DATA      1
`define XV_REG_BLIT_COUNT   2
`define XV_REG_BLIT_VALUE   3
`define XV_REG_INT_CTRL     4
`define XV_REG_STATUS       5       // read only

// interrupt vector bits
`define XV_INTR_VIDEO       1
`define XV_INTR_BLIT        0

`endif

// ==== hw/xosera_main.sv ====
/*
 * video display top level
 * CPU register interface, video generator and fill blitter sharing
 * one VRAM through the arbiter
 */
`default_nettype none

module xosera_main (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_cs_n_i,
    input  wire logic                   bus_rd_nwr_i,
    input  wire xv_bus_pkg::reg_num_t   bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,
    input  wire xv_bus_pkg::bus_byte_t  bus_data_i,
    output xv_bus_pkg::bus_byte_t       bus_data_o,
    output logic                        bus_intr_o,
    output xv_video_pkg::rgb4_t         red_o,
    output xv_video_pkg::rgb4_t         green_o,
    output xv_video_pkg::rgb4_t         blue_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);

xv_video_pkg::word_t    vram_data;      // read data to all clients

logic                   vgen_sel;
logic                   vgen_ack;
xv_video_pkg::addr_t    vgen_addr;
logic                   h_blank;
logic                   v_blank;
logic                   video_intr;

logic                   regs_sel;
logic                   regs_ack;
logic                   regs_wr;
xv_video_pkg::addr_t    regs_addr;
xv_video_pkg::word_t    regs_data;

logic                   blit_start;
xv_video_pkg::word_t    blit_count;
xv_video_pkg::word_t    blit_value;
xv_video_pkg::addr_t    blit_start_addr;
logic                   blit_sel;
logic                   blit_ack;
logic                   blit_wr;
xv_video_pkg::addr_t    blit_addr;
xv_video_pkg::word_t    blit_data;
logic                   blit_busy;
logic                   blit_done;

reg_interface i_reg_interface (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n_i),
    .bus_rd_nwr_i   (bus_rd_nwr_i),
    .bus_reg_num_i  (bus_reg_num_i),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_data_i     (bus_data_i),
    .bus_data_o     (bus_data_o),
    .bus_intr_o     (bus_intr_o),
    .regs_sel_o     (regs_sel),
    .regs_wr_o      (regs_wr),
    .regs_addr_o    (regs_addr),
    .regs_data_o    (regs_data),
    .regs_ack_i     (regs_ack),
    .vram_data_i    (vram_data),
    .blit_start_o   (blit_start),
    .blit_count_o   (blit_count),
    .blit_value_o   (blit_value),
    .blit_addr_o    (blit_start_addr),
    .blit_busy_i    (blit_busy),
    .blit_done_i    (blit_done),        // blit interrupt source
    .h_blank_i      (h_blank),
    .v_blank_i      (v_blank),
    .video_intr_i   (video_intr)        // start of vertical blank
);

video_gen i_video_gen (
    .clk            (clk),
    .reset_i        (reset_i),
    .vram_sel_o     (vgen_sel),
    .vram_addr_o    (vgen_addr),
    .vram_ack_i     (vgen_ack),
    .vram_data_i    (vram_data),
    .red_o          (red_o),
    .green_o        (green_o),
    .blue_o         (blue_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .dv_de_o        (dv_de_o),
    .h_blank_o      (h_blank),
    .v_blank_o      (v_blank),
    .video_intr_o   (video_intr)
);

blit_fill i_blit_fill (
    .clk            (clk),
    .reset_i        (reset_i),
    .start_i        (blit_start),
    .count_i        (blit_count),
    .value_i        (blit_value),
    .addr_i         (blit_start_addr),
    .vram_ack_i     (blit_ack),
    .vram_sel_o     (blit_sel),
    .vram_wr_o      (blit_wr),
    .vram_addr_o    (blit_addr),
    .vram_data_o    (blit_data),
    .busy_o         (blit_busy),
    .done_o         (blit_done)
);

// video first, then blit, then CPU
vram_arb i_vram_arb (
    .clk            (clk),
    .vgen_sel_i     (vgen_sel),
    .vgen_addr_i    (vgen_addr),
    .blit_sel_i     (blit_sel),
    .blit_wr_i      (blit_wr),
    .blit_addr_i    (blit_addr),
    .blit_data_i    (blit_data),
    .regs_sel_i     (regs_sel),
    .regs_wr_i      (regs_wr),
    .regs_addr_i    (regs_addr),
    .regs_data_i    (regs_data),
    .vgen_ack_o     (vgen_ack),
    .blit_ack_o     (blit_ack),
    .regs_ack_o     (regs_ack),
    .vram_data_o    (vram_data)
);

endmodule

`default_nettype wire

// ==== hw/xv_bus_pkg.sv ====
/*
 * CPU bus types
 * data byte, register number and interrupt vector
 */
`default_nettype none

package xv_bus_pkg;

typedef logic [7:0] bus_byte_t;     // one byte on the CPU bus
typedef logic [3:0] reg_num_t;      // register select
typedef logic [1:0] intr_t;         // video and blit bits

endpackage

`default_nettype wire

// ==== hw/xv_video_pkg.sv ====
/*
 * video memory and timing types
 * VRAM address and word, raster counters, colour gun
 */
`default_nettype none
`include "xosera_consts.svh"

package xv_video_pkg;

typedef logic [`XV_ADDR_W-1:0] addr_t;  // VRAM word address
typedef logic [`XV_WORD_W-1:0] word_t;  // four 4-bit pixels
typedef logic [4:0]            hcount_t;    // 0..23
typedef logic [3:0]            vcount_t;    // 0..11
typedef logic [3:0]            rgb4_t;

endpackage

`default_nettype wire

// ==== sim/tb_xosera.sv ====
/*
 * testbench for the video display top level
 * runs bus operations from a trace file through the CPU register
 * interface, checks VRAM round trips, fills, interrupts and the
 * video raster
 */
`default_nettype none
`include "xosera_consts.svh"

module tb_xosera;

localparam int POLL_LIMIT  = 50;    // status reads before giving up
localparam int FRAME_LIMIT = 1000;  // cycles, over three frames

logic                       clk;
logic                       reset_i;
logic                       bus_cs_n;
logic                       bus_rd_nwr;
xv_bus_pkg::reg_num_t       bus_reg_num;
logic                       bus_bytesel;
xv_bus_pkg::bus_byte_t      bus_data_in;
xv_bus_pkg::bus_byte_t      bus_data_out;
logic                       bus_intr;
xv_video_pkg::rgb4_t        red;
xv_video_pkg::rgb4_t        green;
xv_video_pkg::rgb4_t        blue;
logic                       hsync;
logic                       vsync;
logic                       dv_de;

int                         errors;
int                         checks;
logic                       abort;          // a wait timed out
integer                     seed;
int                         intr_pulses = 0;
int                         intr_mark = 0;  // pulse count at last check
xv_video_pkg::word_t        rand_words [0:15];
xv_video_pkg::word_t        shadow_mem [0:(1 << `XV_ADDR_W) - 1];   // CPU writes
xv_video_pkg::addr_t        shadow_addr;

xosera_main i_xosera_main (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n),
    .bus_rd_nwr_i   (bus_rd_nwr),
    .bus_reg_num_i  (bus_reg_num),
    .bus_bytesel_i  (bus_bytesel),
    .bus_data_i     (bus_data_in),
    .bus_data_o     (bus_data_out),
    .bus_intr_o     (bus_intr),
    .red_o          (red),
    .green_o        (green),
    .blue_o         (blue),
    .hsync_o        (hsync),
    .vsync_o        (vsync),
    .dv_de_o        (dv_de)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

// one count per cycle with the strobe high
always @(negedge clk) begin
    if (!reset_i && bus_intr) begin
        intr_pulses <= intr_pulses + 1;
    end
end

task automatic check_value(input string name, input logic [15:0] actual,
                           input logic [15:0] expected);
    begin
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: got %h, expected %h", name, actual, expected);
        end
    end
endtask

task automatic report_timeout(input string what);
    begin
        errors++;
        abort = 1'b1;
        $display("timed out waiting for %s", what);
    end
endtask

// one byte access, data out sampled mid second cycle
task automatic bus_cycle(input logic rd, input xv_bus_pkg::reg_num_t rn, input logic bsel,
                         input xv_bus_pkg::bus_byte_t din, output xv_bus_pkg::bus_byte_t dout);
    begin
        @(posedge clk);
        bus_cs_n    <= 1'b0;
        bus_rd_nwr  <= rd;
        bus_reg_num <= rn;
        bus_bytesel <= bsel;
        bus_data_in <= din;
        @(posedge clk);             // DUT takes the access here
        @(negedge clk);
        dout = bus_data_out;
        @(posedge clk);
        bus_cs_n <= 1'b1;
    end
endtask

task automatic write_reg(input xv_bus_pkg::reg_num_t rn, input xv_video_pkg::word_t value);
    xv_bus_pkg::bus_byte_t unused;
    begin
        bus_cycle(1'b0, rn, 1'b0, value[15:8], unused);    // high byte latch
        bus_cycle(1'b0, rn, 1'b1, value[7:0], unused);     // commit
        if (rn == `XV_REG_XM_ADDR) begin
            shadow_addr = xv_video_pkg::addr_t'(value);
        end
        if (rn == `XV_REG_XM_DATA) begin
            shadow_mem[shadow_addr] = value;
            shadow_addr = shadow_addr + 1'b1;                   // address steps after write
        end
    end
endtask

task automatic read_reg(input xv_bus_pkg::reg_num_t rn, output xv_video_pkg::word_t value);
    xv_bus_pkg::bus_byte_t hi;
    xv_bus_pkg::bus_byte_t lo;
    begin
        bus_cycle(1'b1, rn, 1'b0, 8'h00, hi);
        bus_cycle(1'b1, rn, 1'b1, 8'h00, lo);
        value = {hi, lo};
    end
endtask

// poll STATUS until one busy bit drops
task automatic wait_status_clear(input int bit_idx, input string what);
    xv_video_pkg::word_t status;
    int polls;
    begin
        polls = 0;
        read_reg(`XV_REG_STATUS, status);
        while (status[bit_idx] && polls < POLL_LIMIT && !abort) begin
            read_reg(`XV_REG_STATUS, status);
            polls++;
        end
        if (status[bit_idx] && !abort) begin
            report_timeout(what);
        end
    end
endtask

task automatic read_word_at(input xv_video_pkg::addr_t addr, output xv_video_pkg::word_t word);
    begin
        write_reg(`XV_REG_XM_ADDR, xv_video_pkg::word_t'(addr));   // loads read buffer
        wait_status_clear(0, "reg busy after address write");
        read_reg(`XV_REG_XM_DATA, word);
    end
endtask

// returns at the first negedge with vsync high
task automatic wait_vsync_rise;
    logic prev;
    logic found;
    int n;
    begin
        prev  = 1'b1;   // ignore a pulse already running
        found = 1'b0;
        n     = 0;
        while (!found && n < FRAME_LIMIT && !abort) begin
            @(negedge clk);
            found = vsync && !prev;
            prev  = vsync;
            n++;
        end
        if (!found && !abort) begin
            report_timeout("vsync rising edge");
        end
    end
endtask

// one vsync to vsync period
task automatic measure_frame;
    int cycles;
    int de_cycles;
    int hs_rises;
    int blank_colour;
    logic hs_prev;
    logic vs_prev;
    logic done;
    begin
        cycles       = 0;
        de_cycles    = 0;
        hs_rises     = 0;
        blank_colour = 0;
        hs_prev      = 1'b0;
        vs_prev      = 1'b1;
        done         = 1'b0;
        wait_vsync_rise();
        while (!done && cycles < FRAME_LIMIT && !abort) begin
            if (dv_de) de_cycles++;
            if (!dv_de && (red | green | blue) != 4'h0) blank_colour++;
            if (hsync && !hs_prev) hs_rises++;
            hs_prev = hsync;
            cycles++;
            @(negedge clk);
            done    = vsync && !vs_prev;
            vs_prev = vsync;
        end
        if (!done && !abort) begin
            report_timeout("second vsync rising edge");
        end
        if (!abort) begin
            check_value("frame cycles", cycles, `XV_H_TOTAL * `XV_V_TOTAL);
            check_value("dv_de_o cycles", de_cycles, `XV_H_VISIBLE * `XV_V_VISIBLE);
            check_value("hsync_o rises", hs_rises, `XV_V_TOTAL);
            check_value("colour while blanked", blank_colour, 0);
        end
    end
endtask

// first visible line after the next vsync, msn first
task automatic check_first_line;
    xv_video_pkg::word_t word;
    xv_video_pkg::word_t pix;
    int n;
    int i;
    begin
        n = 0;
        wait_vsync_rise();
        while (!dv_de && n < FRAME_LIMIT && !abort) begin
            @(negedge clk);
            n++;
        end
        if (!dv_de && !abort) begin
            report_timeout("display enable");
        end
        for (i = 0; i < `XV_H_VISIBLE && !abort; i++) begin
            word = shadow_mem[i / 4];
            pix  = (word >> (12 - 4 * (i % 4))) & 16'h000f;
            check_value("red_o", red, pix);
            check_value("green_o", green, pix);   // grey ramp, all guns equal
            check_value("blue_o", blue, pix);
            @(negedge clk);
        end
    end
endtask

// INT_CTRL written just after each vsync, well before line 8
task automatic count_frame_intr(input int frames, input xv_video_pkg::word_t ctrl,
                                input xv_video_pkg::word_t expv);
    int f;
    begin
        wait_vsync_rise();
        intr_mark = intr_pulses;
        for (f = 0; f < frames && !abort; f++) begin
            write_reg(`XV_REG_INT_CTRL, ctrl);
            wait_vsync_rise();
        end
        check_value("bus_intr_o pulses", intr_pulses - intr_mark, expv);
        intr_mark = intr_pulses;
    end
endtask

task automatic run_op(input logic [3:0] op, input xv_bus_pkg::reg_num_t rn,
                      input xv_video_pkg::word_t val, input xv_video_pkg::word_t expv);
    xv_video_pkg::word_t data;
    int i;
    begin
        case (op)
            4'h0: begin
                write_reg(rn, val);
                if (rn == `XV_REG_XM_ADDR || rn == `XV_REG_XM_DATA) begin
                    wait_status_clear(0, "reg busy after write");
                end
            end
            4'h1: begin
                read_reg(rn, data);
                check_value($sformatf("reg %0d", rn), data & val, expv);   // masked
            end
            4'h2: begin
                data = xv_video_pkg::word_t'($random(seed));
                rand_words[val[3:0]] = data;
                write_reg(`XV_REG_XM_DATA, data);
                wait_status_clear(0, "reg busy after random write");
            end
            4'h3: begin
                for (i = 0; i < rn && !abort; i++) begin
                    read_word_at(xv_video_pkg::addr_t'(val + i), data);
                    check_value("XM_DATA", data, rand_words[expv[3:0] + i]);
                end
            end
            4'h4: wait_status_clear(1, "blit busy");
            4'h5: begin
                check_value("bus_intr_o pulses", intr_pulses - intr_mark, expv);
                intr_mark = intr_pulses;
            end
            4'h6: begin
                for (i = 0; i < rn && !abort; i++) begin
                    read_word_at(xv_video_pkg::addr_t'(val + i), data);
                    check_value("XM_DATA", data, expv);
                end
            end
            4'h7: measure_frame();
            4'h8: check_first_line();
            4'h9: count_frame_intr(rn, val, expv);
            default: begin
                errors++;
                $display("unknown operation %h in the trace file", op);
            end
        endcase
    end
endtask

initial begin
    int fd;
    int n;
    reg [8*128-1:0] line;
    logic [3:0] op;
    xv_bus_pkg::reg_num_t rn;
    xv_video_pkg::word_t val;
    xv_video_pkg::word_t expv;
    errors      = 0;
    checks      = 0;
    abort       = 1'b0;
    seed        = 73859;
    shadow_addr = '0;
    reset_i     = 1'b1;
    bus_cs_n    = 1'b1;
    bus_rd_nwr  = 1'b1;
    bus_reg_num = '0;
    bus_bytesel = 1'b0;
    bus_data_in = '0;
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    repeat (2) @(posedge clk);
    fd = $fopen("sim/xosera_trace.txt", "r");
    if (fd == 0) begin
        errors++;
        $display("cannot open the trace file sim/xosera_trace.txt");
    end else begin
        while (!abort && !$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h", op, rn, val, expv);
                if (n == 4) begin   // comment lines do not parse
                    run_op(op, rn, val, expv);
                end
            end
        end
        $fclose(fd);
    end
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
        $display("TEST RESULT: PASS");
    end else begin
        $display("TEST RESULT: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== sim/xosera_trace.txt ====
# op reg value expect, hex; 0 write, 1 read masked by value, 2 random write slot, 3 random check
# 4 fill wait, 5 intr pulses, 6 fixed check, 7 frame timing, 8 line 0 pixels, 9 intr over frames
0 0 0100 0000
2 0 0000 0000
2 0 0001 0000
2 0 0002 0000
2 0 0003 0000
3 4 0100 0000
0 0 0206 0000
0 1 1234 0000
0 1 5678 0000
0 3 A5A5 0000
0 4 01FF 0000
5 0 0000 0000
0 0 0200 0000
0 2 0006 0000
4 0 0000 0000
5 0 0000 0001
6 6 0200 A5A5
6 1 0206 1234
6 1 0207 5678
1 4 0301 0101
0 4 0101 0000
1 4 0001 0000
0 4 0000 0000
0 2 0004 0000
4 0 0000 0000
5 0 0000 0000
7 0 0000 0000
0 0 0000 0000
0 1 0123 0000
0 1 4567 0000
0 1 89AB 0000
0 1 CDEF 0000
8 0 0000 0000
9 3 0202 0003
9 3 0200 0000
